// ==== hw/csd_clock_gen_params.svh ====
`ifndef CSD_CLOCK_GEN_PARAMS_SVH
`define CSD_CLOCK_GEN_PARAMS_SVH

// -------------------------------------------------------------------------
// Bus geometry
// -------------------------------------------------------------------------
`define CSD_ADDR_W 4
`define CSD_DATA_W 32

// Register map, word aligned
`define CSD_ADDR_CONTROL 4'h0
`define CSD_ADDR_PRESCALE 4'h4
`define CSD_ADDR_STATUS 4'h8

// -------------------------------------------------------------------------
// Clock generator timing
// -------------------------------------------------------------------------
// Prescaler reload value width
`define CSD_PRESCALE_W 8
// Scan counter period in op_clock cycles
`define CSD_SCAN_PERIOD 32

// Galois sequence, shift left with feedback from the top bit
`define CSD_PRS_W 16
`define CSD_PRS_POLY 16'hB400
`define CSD_PRS_SEED 16'hFFFF

`endif

// ==== hw/csd_clock_gen_pkg.sv ====
package csd_clock_gen_pkg;

    // ---------------------------------------------------------------------
    // Scan sequencer states
    // ---------------------------------------------------------------------
    // Code is also returned in the low bits of STATUS
    typedef enum logic [1:0]
    {
        SEQ_IDLE     = 2'd0,
        SEQ_RESET    = 2'd1,
        SEQ_MEAS_RST = 2'd2,
        SEQ_WORK     = 2'd3
    } seq_state_t;

    // ---------------------------------------------------------------------
    // CONTROL register fields
    // ---------------------------------------------------------------------
    // Declared msb first, so idac_sink lands on bit 5
    typedef struct packed
    {
        // Current source sinks, shield inverted
        logic idac_sink;
        // Precharge from sequence top bit instead of square wave
        logic prs_sel;
        // Channel enables for the work phase
        logic ch1_en;
        logic ch0_en;
        // Leave measure reset
        logic meas_en;
        // Start and keep the scan running
        logic sync_en;
    } csd_control_t;

    // ---------------------------------------------------------------------
    // AXI4-Lite response codes
    // ---------------------------------------------------------------------
    typedef enum logic [1:0]
    {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

endpackage

// ==== hw/csd_ctrl_if.sv ====
`timescale 1ns/10ps
`include "csd_clock_gen_params.svh"

interface csd_ctrl_if;
    import csd_clock_gen_pkg::*;

    // Decoded CONTROL fields
    csd_control_t control;
    // Prescaler half period minus one
    logic [`CSD_PRESCALE_W-1:0] prescale;
    // Sequencer state, read back through STATUS
    seq_state_t seq_state;

    // Register block owns the configuration
    modport regs (output control, output prescale, input seq_state);

    // Precharge generator only needs the period and the source select
    modport gen (input prescale, input control);

    // Sequencer follows the control bits and reports its state
    modport seq (input control, output seq_state);

endinterface

// ==== hw/csd_ctrl_regs.sv ====
`timescale 1ns/10ps
`include "csd_clock_gen_params.svh"

module csd_ctrl_regs
(
    input  logic                          op_clock,
    input  logic                          inter_reset,
    // Write address
    input  logic [`CSD_ADDR_W-1:0]        awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    // Write data, byte strobes are not decoded
    input  logic [`CSD_DATA_W-1:0]        wdata,
    input  logic [`CSD_DATA_W/8-1:0]      wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    // Write response
    output csd_clock_gen_pkg::axi_resp_t  bresp,
    output logic                          bvalid,
    input  logic                          bready,
    // Read address
    input  logic [`CSD_ADDR_W-1:0]        araddr,
    input  logic                          arvalid,
    output logic                          arready,
    // Read data
    output logic [`CSD_DATA_W-1:0]        rdata,
    output csd_clock_gen_pkg::axi_resp_t  rresp,
    output logic                          rvalid,
    input  logic                          rready,
    csd_ctrl_if.regs                      ctrl
);
    import csd_clock_gen_pkg::*;

    localparam int CTRL_W = $bits(csd_control_t);

    csd_control_t                control_q;
    logic [`CSD_PRESCALE_W-1:0]  prescale_q;
    logic                        wr_fire;
    logic                        rd_fire;
    axi_resp_t                   wr_resp;
    axi_resp_t                   rd_resp;
    logic [`CSD_DATA_W-1:0]      rd_word;

    // -------------------------------------------------------------------------
    // Handshake
    // -------------------------------------------------------------------------
    // Address and data must arrive together, one write in flight
    assign wr_fire = awvalid & wvalid & ~bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    // New read only once the previous response has gone
    assign rd_fire = arvalid & ~rvalid;
    assign arready = rd_fire;

    // Only CONTROL and PRESCALE are writable
    assign wr_resp = ((awaddr == `CSD_ADDR_CONTROL) || (awaddr == `CSD_ADDR_PRESCALE)) ?
                     RESP_OKAY : RESP_SLVERR;

    // -------------------------------------------------------------------------
    // Write path
    // -------------------------------------------------------------------------
    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            control_q  <= '0;
            prescale_q <= '0;
            bvalid     <= 1'b0;
        end
        else if (wr_fire)
        begin
            bvalid <= 1'b1;
            // Error writes leave both registers untouched
            if (awaddr == `CSD_ADDR_CONTROL)
                control_q <= csd_control_t'(wdata[CTRL_W-1:0]);
            else if (awaddr == `CSD_ADDR_PRESCALE)
                prescale_q <= wdata[`CSD_PRESCALE_W-1:0];
        end
        else if (bready)
        begin
            bvalid <= 1'b0;
        end
    end

    // Response code rides with bvalid
    always_ff @(posedge op_clock)
    begin
        if (wr_fire)
            bresp <= wr_resp;
    end

    // -------------------------------------------------------------------------
    // Read path
    // -------------------------------------------------------------------------
    always_comb
    begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        case (araddr)
            `CSD_ADDR_CONTROL:  rd_word[CTRL_W-1:0] = control_q;
            `CSD_ADDR_PRESCALE: rd_word[`CSD_PRESCALE_W-1:0] = prescale_q;
            `CSD_ADDR_STATUS:   rd_word[1:0] = ctrl.seq_state;
            // Unmapped reads as zero
            default:            rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
            rvalid <= 1'b0;
        else if (rd_fire)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    // Data held stable until rready
    always_ff @(posedge op_clock)
    begin
        if (rd_fire)
        begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

    // To the generator and the sequencer
    assign ctrl.control  = control_q;
    assign ctrl.prescale = prescale_q;

endmodule

// ==== hw/csd_precharge_gen.sv ====
`timescale 1ns/10ps
`include "csd_clock_gen_params.svh"

module csd_precharge_gen
(
    input  logic        op_clock,
    input  logic        inter_reset,
    // Held high by the sequencer while the scan restarts
    input  logic        scan_reset,
    csd_ctrl_if.gen     ctrl,
    // Selected precharge clock, before the output register
    output logic        pclk
);
    import csd_clock_gen_pkg::*;

    logic [`CSD_PRESCALE_W-1:0] presc_cnt;
    logic                       sq_wave;
    logic                       step;
    logic                       sq_rise;
    logic [`CSD_PRS_W-1:0]      prs_q;
    logic [`CSD_PRS_W-1:0]      prs_next;

    // -------------------------------------------------------------------------
    // Prescaler
    // -------------------------------------------------------------------------
    // Strobe once per half period when the down-counter hits zero
    assign step = (presc_cnt == '0) & ~scan_reset;

    // Low to high transition of the square wave
    assign sq_rise = step & ~sq_wave;

    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            presc_cnt <= '0;
            sq_wave   <= 1'b0;
        end
        else if (scan_reset)
        begin
            // Restart from a full half period, wave low
            presc_cnt <= ctrl.prescale;
            sq_wave   <= 1'b0;
        end
        else if (step)
        begin
            // Reload gives P+1 cycles per half period
            presc_cnt <= ctrl.prescale;
            sq_wave   <= ~sq_wave;
        end
        else
        begin
            presc_cnt <= presc_cnt - 1'b1;
        end
    end

    // -------------------------------------------------------------------------
    // Pseudo-random sequence
    // -------------------------------------------------------------------------
    // Galois form, shift left and fold the lost top bit back in
    always_comb
    begin
        prs_next = {prs_q[`CSD_PRS_W-2:0], 1'b0};
        if (prs_q[`CSD_PRS_W-1])
            prs_next = prs_next ^ `CSD_PRS_POLY;
    end

    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
            prs_q <= `CSD_PRS_SEED;
        else if (scan_reset)
            prs_q <= `CSD_PRS_SEED;
        else if (sq_rise)
            // One step per prescaler period
            prs_q <= prs_next;
    end

    // -------------------------------------------------------------------------
    // Source select
    // -------------------------------------------------------------------------
    assign pclk = ctrl.control.prs_sel ? prs_q[`CSD_PRS_W-1] : sq_wave;

endmodule

// ==== hw/csd_scan_sequencer.sv ====
`timescale 1ns/10ps
`include "csd_clock_gen_params.svh"

module csd_scan_sequencer
(
    input  logic    op_clock,
    input  logic    inter_reset,
    csd_ctrl_if.seq ctrl,
    // Precharge clock from the generator
    input  logic    pclk,
    output logic    scan_reset,
    output logic    dpulse,
    output logic    ppulse,
    output logic    shield,
    output logic    mesrst,
    output logic    start0,
    output logic    start1
);
    import csd_clock_gen_pkg::*;

    localparam int SCAN_W = $clog2(`CSD_SCAN_PERIOD);
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(`CSD_SCAN_PERIOD - 1);

    seq_state_t        state;
    seq_state_t        state_next;
    logic [SCAN_W-1:0] scan_cnt;

    // -------------------------------------------------------------------------
    // Scan state machine
    // -------------------------------------------------------------------------
    always_comb
    begin
        state_next = state;
        case (state)
            SEQ_IDLE:     if (ctrl.control.sync_en) state_next = SEQ_RESET;
            // Single cycle restart of the counters
            SEQ_RESET:    state_next = SEQ_MEAS_RST;
            SEQ_MEAS_RST: if (ctrl.control.meas_en) state_next = SEQ_WORK;
            SEQ_WORK:     if (!ctrl.control.sync_en) state_next = SEQ_IDLE;
            default:      state_next = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
            state <= SEQ_IDLE;
        else
            state <= state_next;
    end

    assign ctrl.seq_state = state;

    // Registered decode, each output trails its state by one cycle
    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            scan_reset <= 1'b1;
            mesrst     <= 1'b0;
            start0     <= 1'b0;
            start1     <= 1'b0;
        end
        else
        begin
            scan_reset <= (state == SEQ_RESET);
            mesrst     <= (state == SEQ_MEAS_RST);
            start0     <= (state == SEQ_WORK) & ctrl.control.ch0_en;
            start1     <= (state == SEQ_WORK) & ctrl.control.ch1_en;
        end
    end

    // -------------------------------------------------------------------------
    // Scan counter and precharge outputs
    // -------------------------------------------------------------------------
    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            scan_cnt <= '0;
            dpulse   <= 1'b0;
        end
        else if (scan_reset)
        begin
            scan_cnt <= '0;
            dpulse   <= 1'b0;
        end
        else
        begin
            // dpulse follows the last count, one cycle per period
            dpulse <= (scan_cnt == SCAN_LAST);
            if (scan_cnt == SCAN_LAST)
                scan_cnt <= '0;
            else
                scan_cnt <= scan_cnt + 1'b1;
        end
    end

    always_ff @(posedge op_clock or posedge inter_reset)
    begin
        if (inter_reset)
        begin
            ppulse <= 1'b0;
            shield <= 1'b0;
        end
        else
        begin
            ppulse <= pclk;
            // Shield opposes the precharge when the current source sinks
            shield <= pclk ^ ctrl.control.idac_sink;
        end
    end

endmodule

// ==== hw/csd_clock_gen.sv ====
`timescale 1ns/10ps
`include "csd_clock_gen_params.svh"

module csd_clock_gen
(
    input  logic                      op_clock,
    input  logic                      inter_reset,
    // AXI4-Lite slave
    input  logic [`CSD_ADDR_W-1:0]    awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`CSD_DATA_W-1:0]    wdata,
    input  logic [`CSD_DATA_W/8-1:0]  wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`CSD_ADDR_W-1:0]    araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`CSD_DATA_W-1:0]    rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    // Sense clocks
    output logic                      dpulse,
    output logic                      ppulse,
    output logic                      shield,
    output logic                      mesrst,
    output logic                      start0,
    output logic                      start1
);

    // Counter restart from the sequencer
    logic scan_reset;
    // Precharge clock back to the output stage
    logic pclk;

    csd_ctrl_if ctrl_bus ();

    // -------------------------------------------------------------------------
    // Register block, generator, sequencer
    // -------------------------------------------------------------------------
    csd_ctrl_regs u_regs
    (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .ctrl        (ctrl_bus.regs)
    );

    csd_precharge_gen u_gen
    (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .scan_reset  (scan_reset),
        .ctrl        (ctrl_bus.gen),
        .pclk        (pclk)
    );

    csd_scan_sequencer u_seq
    (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .ctrl        (ctrl_bus.seq),
        .pclk        (pclk),
        .scan_reset  (scan_reset),
        .dpulse      (dpulse),
        .ppulse      (ppulse),
        .shield      (shield),
        .mesrst      (mesrst),
        .start0      (start0),
        .start1      (start1)
    );

endmodule

// ==== tests/csd_clock_gen_assertions.sv ====
`timescale 1ns/10ps

module csd_clock_gen_assertions
(
    input logic op_clock,
    input logic inter_reset,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic dpulse,
    input logic mesrst,
    input logic start0,
    input logic start1
);

    // ------------------------------------------------------------------------
    // Bus responses
    // ------------------------------------------------------------------------
    // Write response held until taken
    bvalid_held: assert property (@(posedge op_clock) disable iff (inter_reset)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    // Read response held until taken
    rvalid_held: assert property (@(posedge op_clock) disable iff (inter_reset)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // ------------------------------------------------------------------------
    // Sense outputs
    // ------------------------------------------------------------------------
    // One cycle scan pulse
    dpulse_single: assert property (@(posedge op_clock) disable iff (inter_reset)
        dpulse |=> !dpulse)
        else $error("dpulse high for two cycles in a row");

    // No channel starts while the measure reset is on
    start_in_mesrst: assert property (@(posedge op_clock) disable iff (inter_reset)
        mesrst |-> !(start0 || start1))
        else $error("start0 or start1 high during mesrst");

endmodule

// ==== tests/csd_clock_gen_tb.sv ====
`timescale 1ns/10ps
`include "csd_clock_gen_params.svh"

module csd_clock_gen_tb;
    import csd_clock_gen_pkg::*;

    // Five tests take under 2000 cycles so this limit leaves a wide margin
    localparam int CYCLE_LIMIT = 20000;
    // Output selectors for the polling task
    localparam int SIG_MESRST = 0;
    localparam int SIG_START0 = 1;
    localparam int SIG_START1 = 2;
    localparam int SIG_DPULSE = 3;

    logic        op_clock;
    logic        inter_reset;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        dpulse;
    logic        ppulse;
    logic        shield;
    logic        mesrst;
    logic        start0;
    logic        start1;

    int checks;
    int errors;
    int errors_at_start;
    int cycle_count;

    csd_clock_gen csd_clock_gen_i (.*);

    bind csd_clock_gen csd_clock_gen_assertions u_assertions
    (
        .op_clock    (op_clock),
        .inter_reset (inter_reset),
        .bvalid      (bvalid),
        .bready      (bready),
        .rvalid      (rvalid),
        .rready      (rready),
        .dpulse      (dpulse),
        .mesrst      (mesrst),
        .start0      (start0),
        .start1      (start1)
    );

    // ------------------------------------------------------------------------
    // Clock and run limit
    // ------------------------------------------------------------------------
    initial
    begin
        op_clock = 1'b0;
        forever #10 op_clock = ~op_clock;
    end

    always @(posedge op_clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Reference models
    // ------------------------------------------------------------------------
    // One Galois step shifts left and folds the lost top bit back with the polynomial
    function automatic logic [15:0] prs_model_step(input logic [15:0] value);
        logic [15:0] shifted;
        shifted = {value[14:0], 1'b0};
        if (value[15])
            shifted = shifted ^ 16'hB400;
        return shifted;
    endfunction

    // Readback keeps only the implemented field bits
    function automatic logic [31:0] control_readback(input logic [31:0] written);
        return written & 32'h0000_003F;
    endfunction

    function automatic logic [31:0] prescale_readback(input logic [31:0] written);
        return written & 32'h0000_00FF;
    endfunction

    // Square wave spends P+1 cycles at each level
    function automatic int half_period(input int presc);
        return presc + 1;
    endfunction

    function automatic logic probe(input int sel);
        case (sel)
            SIG_MESRST: return mesrst;
            SIG_START0: return start0;
            SIG_START1: return start1;
            default:    return dpulse;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Compare and bookkeeping
    // ------------------------------------------------------------------------
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("Error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got,
                     expected);
        end
    endtask

    task automatic report_test(input string name);
        $display("%s finished with %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge op_clock);
        #2;
    endtask

    task automatic wait_for(input int sel, input logic level, input int max_cycles,
                            input string what);
        int n;
        n = 0;
        while (probe(sel) !== level && n < max_cycles)
        begin
            next_cycle();
            n++;
        end
        checks++;
        if (probe(sel) !== level)
        begin
            errors++;
            $display("At %0t ns %s did not happen within %0d cycles", $time, what, max_cycles);
        end
    endtask

    // ------------------------------------------------------------------------
    // AXI4-Lite master tasks
    // ------------------------------------------------------------------------
    // Ready is sampled at the falling edge where it already matches the next rising edge
    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int gap;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        @(negedge op_clock);
        while (!(awready && wready))
            @(negedge op_clock);
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // Random back-pressure on the response channel
        gap = $urandom_range(0, 3);
        repeat (gap)
            next_cycle();
        bready = 1'b1;
        @(negedge op_clock);
        while (!bvalid)
            @(negedge op_clock);
        resp = bresp;
        next_cycle();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int gap;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b0;
        @(negedge op_clock);
        while (!arready)
            @(negedge op_clock);
        next_cycle();
        arvalid = 1'b0;
        gap = $urandom_range(0, 3);
        repeat (gap)
            next_cycle();
        rready = 1'b1;
        @(negedge op_clock);
        while (!rvalid)
            @(negedge op_clock);
        data = rdata;
        resp = rresp;
        next_cycle();
        rready = 1'b0;
    endtask

    // Back to idle, new period, then restart held in measure reset.
    // Returns at the first dpulse which comes 32 cycles after scan_reset fell
    task automatic restart_scan(input logic [31:0] control, input logic [31:0] presc);
        logic [1:0] resp;
        axi_write(`CSD_ADDR_CONTROL, 32'h02, resp);
        axi_write(`CSD_ADDR_PRESCALE, presc, resp);
        axi_write(`CSD_ADDR_CONTROL, control, resp);
        wait_for(SIG_MESRST, 1'b1, 10, "mesrst after the scan restart");
        wait_for(SIG_DPULSE, 1'b1, 40, "first dpulse after the scan restart");
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    initial
    begin : main
        logic [31:0] value;
        logic [31:0] data;
        logic [1:0]  resp;
        logic [15:0] prs_model;
        logic        level;
        int          seed_init;
        int          n;
        int          t;
        int          steps;
        int          presc_list[3];

        seed_init = $urandom(17);
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = 4'hF;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        checks = 0;
        errors = 0;
        errors_at_start = 0;
        inter_reset = 1'b1;
        repeat (2)
            @(posedge op_clock);
        #2;
        inter_reset = 1'b0;
        next_cycle();

        // Register readback with random values
        for (int i = 0; i < 4; i++)
        begin
            value = $urandom;
            axi_write(`CSD_ADDR_CONTROL, value, resp);
            check_value("CONTROL write response", resp, RESP_OKAY);
            axi_read(`CSD_ADDR_CONTROL, data, resp);
            check_value("CONTROL readback", data, control_readback(value));
            value = $urandom;
            axi_write(`CSD_ADDR_PRESCALE, value, resp);
            check_value("PRESCALE write response", resp, RESP_OKAY);
            axi_read(`CSD_ADDR_PRESCALE, data, resp);
            check_value("PRESCALE readback", data, prescale_readback(value));
        end
        axi_write(`CSD_ADDR_CONTROL, 32'h0000_0002, resp);
        axi_write(4'hC, 32'hFFFF_FFFF, resp);
        check_value("unmapped write response", resp, RESP_SLVERR);
        axi_read(4'hC, data, resp);
        check_value("unmapped read response", resp, RESP_SLVERR);
        check_value("unmapped read data", data, 32'h0);
        axi_write(`CSD_ADDR_STATUS, 32'hFFFF_FFFF, resp);
        check_value("STATUS write response", resp, RESP_SLVERR);
        axi_read(`CSD_ADDR_CONTROL, data, resp);
        check_value("CONTROL after error writes", data, 32'h0000_0002);
        axi_write(`CSD_ADDR_CONTROL, 32'h0, resp);
        axi_read(`CSD_ADDR_STATUS, data, resp);
        check_value("STATUS in idle", data, SEQ_IDLE);
        report_test("register readback");

        // Sequencer states and outputs
        axi_write(`CSD_ADDR_CONTROL, 32'h05, resp);
        wait_for(SIG_MESRST, 1'b1, 10, "mesrst rising after sync_en");
        check_value("start0 in measure reset", start0, 1'b0);
        check_value("start1 in measure reset", start1, 1'b0);
        axi_read(`CSD_ADDR_STATUS, data, resp);
        check_value("STATUS in measure reset", data, SEQ_MEAS_RST);
        axi_write(`CSD_ADDR_CONTROL, 32'h07, resp);
        wait_for(SIG_START0, 1'b1, 10, "start0 rising after meas_en");
        check_value("mesrst in work", mesrst, 1'b0);
        check_value("start1 with ch1_en clear", start1, 1'b0);
        axi_read(`CSD_ADDR_STATUS, data, resp);
        check_value("STATUS in work", data, SEQ_WORK);
        axi_write(`CSD_ADDR_CONTROL, 32'h0B, resp);
        wait_for(SIG_START1, 1'b1, 10, "start1 rising after ch1_en");
        check_value("start0 with ch0_en clear", start0, 1'b0);
        axi_write(`CSD_ADDR_CONTROL, 32'h00, resp);
        wait_for(SIG_START1, 1'b0, 10, "start1 falling after sync_en cleared");
        check_value("mesrst after sync_en cleared", mesrst, 1'b0);
        check_value("start0 after sync_en cleared", start0, 1'b0);
        axi_read(`CSD_ADDR_STATUS, data, resp);
        check_value("STATUS back in idle", data, SEQ_IDLE);
        report_test("sequencer");

        // Scan pulse spacing
        restart_scan(32'h01, 32'd5);
        for (int k = 0; k < 4; k++)
        begin
            n = 0;
            do
            begin
                next_cycle();
                n++;
            end
            while (!dpulse && n < 64);
            check_value("dpulse spacing", n, `CSD_SCAN_PERIOD);
        end
        report_test("scan pulse");

        // Square wave half periods measured from the first toggle
        presc_list = '{2, 5, 9};
        foreach (presc_list[p])
        begin
            restart_scan(32'h01, presc_list[p]);
            level = ppulse;
            n = 0;
            while (ppulse === level && n < 2 * half_period(presc_list[p]) + 2)
            begin
                next_cycle();
                n++;
            end
            for (int k = 0; k < 4; k++)
            begin
                level = ppulse;
                n = 0;
                do
                begin
                    check_value("shield follows ppulse", shield, ppulse);
                    next_cycle();
                    n++;
                end
                while (ppulse === level && n < 64);
                check_value("ppulse half period", n, half_period(presc_list[p]));
            end
        end
        report_test("prescaler square wave");

        // Sequence bits sampled mid step where P = 3 gives an 8 cycle step
        restart_scan(32'h31, 32'd3);
        prs_model = 16'hFFFF;
        steps = 0;
        t = 32;
        for (int k = 0; k < 20; )
        begin
            next_cycle();
            t++;
            // ppulse moves at t = P+2 + m*2(P+1) and the middle is P+1 later
            if ((t - 5) % 8 == 4)
            begin
                while (steps < (t - 5) / 8 + 1)
                begin
                    prs_model = prs_model_step(prs_model);
                    steps++;
                end
                check_value("ppulse sequence bit", ppulse, prs_model[15]);
                check_value("shield inverted with idac_sink", shield, !prs_model[15]);
                k++;
            end
        end
        report_test("sequence and shield");

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hw
hw/csd_clock_gen_pkg.sv
hw/csd_ctrl_if.sv
hw/csd_ctrl_regs.sv
hw/csd_precharge_gen.sv
hw/csd_scan_sequencer.sv
hw/csd_clock_gen.sv
tests/csd_clock_gen_assertions.sv
tests/csd_clock_gen_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the clock generator testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module csd_clock_gen_tb -Mdir obj_dir \
    && ./obj_dir/Vcsd_clock_gen_tb > sim.log 2>&1 \
    || echo "Build or simulation returned an error" >> sim.log

cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0
